// File: list.f
common/rvIsaPkg.sv
common/coreCfgPkg.sv
core/alu.sv
core/registerFile.sv
core/controlUnit.sv
core/pcUnit.sv
core/requestUnit.sv
core/datapath.sv
verif/memModel.sv
verif/tbDatapath.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - files:
      - common/rvIsaPkg.sv
      - common/coreCfgPkg.sv
      - core/alu.sv
      - core/registerFile.sv
      - core/controlUnit.sv
      - core/pcUnit.sv
      - core/requestUnit.sv
      - core/datapath.sv
  - target: test
    files:
      - verif/memModel.sv
      - verif/tbDatapath.sv

// File: verif/tbDatapath.sv
module tbDatapath;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] nextPc;
        logic        store;
        logic [31:0] addr;
        logic [31:0] data;
    } expT;

    logic                clk;
    logic                rst;
    logic                iAck;
    logic                dAck;
    logic [31:0]         instruction;
    logic [31:0]         memload;
    logic [31:0]         iAddress;
    coreCfgPkg::dataReqT dReq;

    int          seed = 32'h72a8_81f9;
    int          errors = 0;
    int          checks = 0;
    int          retired = 0;
    int          progLen = 0;
    int          storeOff = 0;
    bit          done = 0;
    bit          pending = 0;
    expT         pendExp;
    logic [31:0] mRegs [32];
    logic [31:0] mMem [256];
    logic [31:0] mPc;
    logic [31:0] endPc;

    always #50 clk = ~clk;

    datapath u_datapath (.*);
    memModel u_mem (.*);

    task automatic compareWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rvIsaPkg::opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
    endfunction

    task automatic put(input logic [31:0] word);
        u_mem.imem[progLen] = word;
        progLen++;
    endtask

    // sw rs, storeOff(x3) with a fresh slot each time
    task automatic storeReg(input logic [4:0] rs);
        logic [11:0] off;
        off = storeOff[11:0];
        put({off[11:5], rs, 5'd3, 3'b010, off[4:0], rvIsaPkg::opStore});
        storeOff += 4;
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [2:0]  brF3 [6];
        brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int k = 1; k <= 2; k++) begin
            r = $random(seed);
            put({r[31:12], k[4:0], rvIsaPkg::opLui});
            put(encI(rvIsaPkg::opImm, 3'b000, k[4:0], k[4:0], r[11:0]));
        end
        put(encI(rvIsaPkg::opImm, 3'b000, 5'd3, 5'd0, 12'h200));
        for (int f = 0; f < 8; f++) begin
            put(encR(7'd0, f[2:0], 5'd4, 5'd1, 5'd2));
            storeReg(5'd4);
            if (f == 0 || f == 5) begin
                put(encR(rvIsaPkg::funct7Alt, f[2:0], 5'd4, 5'd1, 5'd2));
                storeReg(5'd4);
            end
            r = $random(seed);
            if (f == 1 || f == 5) r[11:5] = 7'd0;  // shifts take only a shamt
            put(encI(rvIsaPkg::opImm, f[2:0], 5'd4, 5'd1, r[11:0]));
            storeReg(5'd4);
            if (f == 5) begin
                put(encI(rvIsaPkg::opImm, 3'b101, 5'd4, 5'd2, {rvIsaPkg::funct7Alt, r[4:0]}));
                storeReg(5'd4);
            end
        end
        r = $random(seed);
        put(encI(rvIsaPkg::opLoad, 3'b010, 5'd5, 5'd0, 12'h080));
        put(encI(rvIsaPkg::opImm, 3'b000, 5'd5, 5'd5, r[11:0]));
        storeReg(5'd5);
        // each branch skips one counter increment when taken
        for (int b = 0; b < 6; b++) begin
            put(encB(brF3[b], 5'd1, 5'd1, 13'd8));
            put(encI(rvIsaPkg::opImm, 3'b000, 5'd7, 5'd7, 12'd1));
            put(encB(brF3[b], 5'd1, 5'd2, 13'd8));
            put(encI(rvIsaPkg::opImm, 3'b000, 5'd7, 5'd7, 12'd1));
            put(encB(brF3[b], 5'd2, 5'd1, 13'd8));
            put(encI(rvIsaPkg::opImm, 3'b000, 5'd7, 5'd7, 12'd1));
        end
        storeReg(5'd7);
        put(encJ(5'd8, 21'd8));
        put(encI(rvIsaPkg::opImm, 3'b000, 5'd7, 5'd7, 12'd1));
        storeReg(5'd8);
        r = (progLen + 3) * 4;
        put(encI(rvIsaPkg::opImm, 3'b000, 5'd9, 5'd0, r[11:0]));
        put(encI(rvIsaPkg::opJalr, 3'b000, 5'd10, 5'd9, 12'd0));
        put(encI(rvIsaPkg::opImm, 3'b000, 5'd7, 5'd7, 12'd1));
        storeReg(5'd10);
        put(encI(rvIsaPkg::opImm, 3'b000, 5'd0, 5'd1, 12'd5));
        storeReg(5'd0);
        put(encJ(5'd0, 21'd4));
        storeReg(5'd0);
        endPc = progLen * 4;
    endtask

    // instruction-set model that executes one instruction per call
    function automatic expT step(input logic [31:0] ins);
        expT         e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] immI;
        logic [2:0]  f3;
        logic        alt;
        logic        wr;
        logic        taken;
        e     = '0;
        a     = mRegs[ins[19:15]];
        b     = mRegs[ins[24:20]];
        f3    = ins[14:12];
        immI  = {{20{ins[31]}}, ins[31:20]};
        e.nextPc = mPc + 4;
        wr    = 1'b1;
        res   = '0;
        taken = 1'b0;
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                alt = ins[30] && (ins[5] || f3 == 3'b101);
                if (!ins[5]) b = immI;
                case (f3)
                    3'b000: res = alt ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b010: res = {31'd0, $signed(a) < $signed(b)};
                    3'b011: res = {31'd0, a < b};
                    3'b100: res = a ^ b;
                    3'b101: begin
                        if (alt) res = $signed(a) >>> b[4:0];
                        else res = a >> b[4:0];
                    end
                    3'b110: res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0110111: res = {ins[31:12], 12'd0};
            7'b0000011: begin
                e.addr = a + immI;
                res    = mMem[e.addr[9:2]];
            end
            7'b0100011: begin
                wr      = 1'b0;
                e.store = 1'b1;
                e.addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                e.data  = b;
                mMem[e.addr[9:2]] = b;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (f3)
                    3'b000: taken = a == b;
                    3'b001: taken = a != b;
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) e.nextPc = mPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                             ins[11:8], 1'b0};
            end
            7'b1101111: begin
                res      = mPc + 4;
                e.nextPc = mPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                res      = mPc + 4;
                e.nextPc = (a + immI) & ~32'd1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) mRegs[ins[11:7]] = res;
        mPc = e.nextPc;
        return e;
    endfunction

    always @(posedge clk) begin : compare
        logic                iSeen;
        logic                dSeen;
        logic                retiring;
        logic [31:0]         insSeen;
        logic [31:0]         addrSeen;
        coreCfgPkg::dataReqT reqSeen;
        expT                 e;
        iSeen    = iAck;
        dSeen    = dAck;
        insSeen  = instruction;
        addrSeen = iAddress;
        reqSeen  = dReq;
        retiring = 1'b0;
        if (!rst && !done) begin
            if (pending) begin
                if (dSeen) begin
                    compareWord("dReq.write", pendExp.store, reqSeen.write);
                    compareWord("dReq.read", !pendExp.store, reqSeen.read);
                    compareWord("dReq.address", pendExp.addr, reqSeen.address);
                    if (pendExp.store) begin
                        compareWord("dReq.storeData", pendExp.data, reqSeen.storeData);
                    end
                    e        = pendExp;
                    pending  = 1'b0;
                    retiring = 1'b1;
                end
            end else if (iSeen) begin
                if (insSeen[6:0] == 7'b0000011 || insSeen[6:0] == 7'b0100011) begin
                    pendExp = step(insSeen);
                    pending = 1'b1;
                end else begin
                    e        = step(insSeen);
                    retiring = 1'b1;
                end
            end else if (reqSeen.read || reqSeen.write) begin
                errors++;
                $display("data request raised at %0t while no fetch was acknowledged", $time);
            end
            @(negedge clk);
            if (retiring) begin
                compareWord("iAddress", e.nextPc, iAddress);
                retired++;
                if (e.nextPc == endPc) done = 1'b1;
            end else begin
                compareWord("iAddress", addrSeen, iAddress);  // held while waiting
            end
        end
    end

    initial begin
        int idle;
        int lastRetired;
        clk = 1'b0;
        rst = 1'b1;
        #1;
        buildProgram();
        for (int i = 0; i < 32; i++) mRegs[i] = '0;
        for (int i = 0; i < 256; i++) mMem[i] = u_mem.fillWord(i);
        mPc = coreCfgPkg::resetPc;
        repeat (3) @(posedge clk);
        #5 rst = 1'b0;
        compareWord("iAddress", coreCfgPkg::resetPc, iAddress);
        idle = 0;
        while (!iAck && idle < 20) begin
            @(posedge clk);
            if (dReq.read || dReq.write) begin
                errors++;
                $display("data request active before the first instruction fetch");
            end
            idle++;
        end
        if (!iAck && idle >= 20) begin
            errors++;
            $display("timeout while waiting for the first instruction acknowledge");
        end
        idle = 0;
        lastRetired = retired;
        while (!done && idle < 100) begin
            @(posedge clk);
            idle = (retired != lastRetired) ? 0 : idle + 1;
            lastRetired = retired;
        end
        if (!done) begin
            errors++;
            $display("timeout: the core stopped retiring instructions before the program end");
        end
        $display("checks %0d, retired %0d, errors %0d", checks, retired, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verif/memModel.sv
module memModel (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [coreCfgPkg::xlen-1:0] iAddress,
    input  coreCfgPkg::dataReqT         dReq,
    output logic [coreCfgPkg::xlen-1:0] instruction,
    output logic [coreCfgPkg::xlen-1:0] memload,
    output logic                        iAck,
    output logic                        dAck
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]         imem [256];
    logic [31:0]         dmem [256];
    int                  seed = 32'h72a8_81f9;
    int                  iWait;
    int                  dWait;
    coreCfgPkg::dataReqT reqSeen;
    logic                iSeen;
    logic                dSeen;

    // every data word differs from its neighbours across the whole index
    function automatic logic [31:0] fillWord(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0f0f ^ (idx << 16);
    endfunction

    function automatic int ackDelay();
        return $unsigned($random(seed)) % 4;
    endfunction

    initial begin
        iAck  = 1'b0;
        dAck  = 1'b0;
        iWait = 0;
        dWait = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fillWord(i);
            // xori x0 with an index-derived immediate, harmless past the program
            imem[i] = {4'ha, i[7:0], 5'd0, 3'b100, 5'd0, rvIsaPkg::opImm};
        end
    end

    assign instruction = imem[iAddress[9:2]];
    assign memload     = dmem[dReq.address[9:2]];

    always @(posedge clk) begin
        reqSeen = dReq;
        iSeen   = iAck;
        dSeen   = dAck;
        if (!rst && dSeen && reqSeen.write) begin
            dmem[reqSeen.address[9:2]] = reqSeen.storeData;  // store lands on the dAck edge
        end
        #5;
        if (rst) begin
            iAck  = 1'b0;
            dAck  = 1'b0;
            iWait = ackDelay();
            dWait = ackDelay();
        end else begin
            if (iSeen) begin
                iAck  = 1'b0;
                iWait = ackDelay();
            end else if (!(dReq.read || dReq.write)) begin
                if (iWait == 0) iAck = 1'b1;
                else iWait--;
            end
            if (dSeen) begin
                dAck  = 1'b0;
                dWait = ackDelay();
            end else if (dReq.read || dReq.write) begin
                if (dWait == 0) dAck = 1'b1;
                else dWait--;
            end
        end
    end

endmodule

// File: core/datapath.sv
module datapath (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          iAck,
    input  logic                          dAck,
    input  logic [coreCfgPkg::xlen-1:0]   instruction,
    input  logic [coreCfgPkg::xlen-1:0]   memload,
    output logic [coreCfgPkg::xlen-1:0]   iAddress,
    output coreCfgPkg::dataReqT           dReq
);

    coreCfgPkg::ctrlT                  ctrl;
    logic [coreCfgPkg::xlen-1:0]       imm;
    logic [coreCfgPkg::regIdxW-1:0]    rs1Idx;
    logic [coreCfgPkg::regIdxW-1:0]    rs2Idx;
    logic [coreCfgPkg::regIdxW-1:0]    rdIdx;
    logic [coreCfgPkg::xlen-1:0]       srcA;
    logic [coreCfgPkg::xlen-1:0]       srcB;
    logic [coreCfgPkg::xlen-1:0]       aluInB;
    logic [coreCfgPkg::xlen-1:0]       aluResult;
    logic                              branchFlag;
    rvIsaPkg::branchFunct3T            branchFunct;
    logic [coreCfgPkg::xlen-1:0]       pc;
    logic [coreCfgPkg::xlen-1:0]       pcPlus4;
    logic [coreCfgPkg::xlen-1:0]       linkOrResult;
    logic [coreCfgPkg::xlen-1:0]       writeBackData;
    logic                              freeze;
    logic                              regWriteEn;

    assign pcPlus4 = pc + 32'd4;

    // nothing is written back until the instruction retires
    assign regWriteEn = ctrl.regWrite && !freeze;

    registerFile u_registerFile (
        .clk        (clk),
        .rst        (rst),
        .writeEnable(regWriteEn),
        .rs1        (rs1Idx),
        .rs2        (rs2Idx),
        .rd         (rdIdx),
        .writeData  (writeBackData),
        .readData1  (srcA),
        .readData2  (srcB)
    );

    controlUnit u_controlUnit (
        .instruction(instruction),
        .branchFlag (branchFlag),
        .ctrl       (ctrl),
        .imm        (imm),
        .rs1        (rs1Idx),
        .rs2        (rs2Idx),
        .rd         (rdIdx)
    );

    assign aluInB      = ctrl.aluSrc ? imm : srcB;
    assign branchFunct = rvIsaPkg::branchFunct3T'(
        instruction[rvIsaPkg::funct3Msb:rvIsaPkg::funct3Lsb]);

    alu u_alu (
        .srcA       (srcA),
        .srcB       (aluInB),
        .aluOp      (ctrl.aluOp),
        .branchFunct(branchFunct),
        .result     (aluResult),
        .branchFlag (branchFlag)
    );

    // jumps link the return address, loads take the memory word
    assign linkOrResult  = (ctrl.jal || ctrl.jalr) ? pcPlus4 : aluResult;
    assign writeBackData = ctrl.memToReg ? memload : linkOrResult;

    pcUnit u_pcUnit (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .imm       (imm),
        .jalrTarget(aluResult),
        .freeze    (freeze),
        .pc        (pc)
    );

    requestUnit u_requestUnit (
        .clk       (clk),
        .rst       (rst),
        .iAck      (iAck),
        .dAck      (dAck),
        .ctrl      (ctrl),
        .pc        (pc),
        .memAddress(aluResult),
        .storeData (srcB),
        .iAddress  (iAddress),
        .dReq      (dReq),
        .freeze    (freeze)
    );

endmodule

// File: core/requestUnit.sv
module requestUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        iAck,
    input  logic                        dAck,
    input  coreCfgPkg::ctrlT            ctrl,
    input  logic [coreCfgPkg::xlen-1:0] pc,
    input  logic [coreCfgPkg::xlen-1:0] memAddress,
    input  logic [coreCfgPkg::xlen-1:0] storeData,
    output logic [coreCfgPkg::xlen-1:0] iAddress,
    output coreCfgPkg::dataReqT         dReq,
    output logic                        freeze
);

    typedef enum logic {
        fetch,
        data
    } stateT;

    stateT state;
    stateT nextState;
    logic  memOp;

    assign memOp    = ctrl.memRead || ctrl.memWrite;
    assign iAddress = pc;  // the fetch address only moves when pc does

    always_comb begin
        nextState = state;
        freeze    = 1'b1;
        dReq      = '0;
        case (state)
            fetch: begin
                if (iAck && memOp) begin
                    nextState = data;
                end
                freeze = !(iAck && !memOp);
            end
            data: begin
                dReq.address   = memAddress;
                dReq.storeData = storeData;
                dReq.read      = ctrl.memRead;
                dReq.write     = ctrl.memWrite;
                if (dAck) begin
                    nextState = fetch;
                    freeze    = 1'b0;
                end
            end
            default: nextState = fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch;
        end else begin
            state <= nextState;
        end
    end

    // a pending access must not change under the memory until it is acknowledged
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
        (state == data && !dAck) |=> $stable(dReq))
        else $error("data request changed before dAck");

endmodule

// File: core/pcUnit.sv
module pcUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  coreCfgPkg::ctrlT            ctrl,
    input  logic [coreCfgPkg::xlen-1:0] imm,
    input  logic [coreCfgPkg::xlen-1:0] jalrTarget,
    input  logic                        freeze,
    output logic [coreCfgPkg::xlen-1:0] pc
);

    logic [coreCfgPkg::xlen-1:0] nextPc;

    always_comb begin
        if (ctrl.jalr) begin
            nextPc = {jalrTarget[coreCfgPkg::xlen-1:1], 1'b0};
        end else if (ctrl.jal || ctrl.branch) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= coreCfgPkg::resetPc;
        end else if (!freeze) begin  // advance only when the instruction retires
            pc <= nextPc;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("program counter left word alignment: %h", pc);

endmodule

// File: core/controlUnit.sv
module controlUnit (
    input  logic [coreCfgPkg::xlen-1:0]    instruction,
    input  logic                           branchFlag,
    output coreCfgPkg::ctrlT               ctrl,
    output logic [coreCfgPkg::xlen-1:0]    imm,
    output logic [coreCfgPkg::regIdxW-1:0] rs1,
    output logic [coreCfgPkg::regIdxW-1:0] rs2,
    output logic [coreCfgPkg::regIdxW-1:0] rd
);

    rvIsaPkg::opcodeT opcode;
    logic [2:0]       funct3;
    logic             altOp;

    // the funct3 group shared by register and immediate forms
    function automatic coreCfgPkg::aluOpT decodeAluOp(
        input logic [2:0] f3,
        input logic       alt,
        input logic       isReg
    );
        coreCfgPkg::aluOpT op;
        case (rvIsaPkg::aluFunct3T'(f3))
            rvIsaPkg::f3Add:  op = (isReg && alt) ? coreCfgPkg::aluSub : coreCfgPkg::aluAdd;
            rvIsaPkg::f3Sll:  op = coreCfgPkg::aluSll;
            rvIsaPkg::f3Slt:  op = coreCfgPkg::aluSlt;
            rvIsaPkg::f3Sltu: op = coreCfgPkg::aluSltu;
            rvIsaPkg::f3Xor:  op = coreCfgPkg::aluXor;
            rvIsaPkg::f3Sr:   op = alt ? coreCfgPkg::aluSra : coreCfgPkg::aluSrl;
            rvIsaPkg::f3Or:   op = coreCfgPkg::aluOr;
            rvIsaPkg::f3And:  op = coreCfgPkg::aluAnd;
            default:          op = coreCfgPkg::aluAdd;
        endcase
        return op;
    endfunction

    assign opcode = rvIsaPkg::opcodeT'(instruction[rvIsaPkg::opcodeMsb:rvIsaPkg::opcodeLsb]);
    assign funct3 = instruction[rvIsaPkg::funct3Msb:rvIsaPkg::funct3Lsb];
    assign altOp  = instruction[rvIsaPkg::funct7Msb:rvIsaPkg::funct7Lsb] == rvIsaPkg::funct7Alt;
    assign rd     = instruction[rvIsaPkg::rdMsb:rvIsaPkg::rdLsb];
    assign rs1    = instruction[rvIsaPkg::rs1Msb:rvIsaPkg::rs1Lsb];
    assign rs2    = instruction[rvIsaPkg::rs2Msb:rvIsaPkg::rs2Lsb];

    always_comb begin
        ctrl = '0;
        imm  = {{20{instruction[31]}}, instruction[31:20]};  // I form unless overridden
        case (opcode)
            rvIsaPkg::opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = decodeAluOp(funct3, altOp, 1'b1);
            end
            rvIsaPkg::opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodeAluOp(funct3, altOp, 1'b0);
            end
            rvIsaPkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = coreCfgPkg::aluPassB;
                imm           = {instruction[31:12], 12'b0};
            end
            rvIsaPkg::opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            rvIsaPkg::opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            rvIsaPkg::opBranch: begin
                ctrl.branch = branchFlag;  // only a taken branch redirects the PC
                ctrl.aluOp  = coreCfgPkg::aluSub;
                imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            rvIsaPkg::opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;
                imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            rvIsaPkg::opJalr: begin
                ctrl.regWrite = 1'b1;
                ctrl.jalr     = 1'b1;
                ctrl.aluSrc   = 1'b1;  // target is rs1 plus the I immediate
            end
            default: ;  // unsupported opcodes execute as a no-op
        endcase
    end

endmodule

// File: core/registerFile.sv
module registerFile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           writeEnable,
    input  logic [coreCfgPkg::regIdxW-1:0] rs1,
    input  logic [coreCfgPkg::regIdxW-1:0] rs2,
    input  logic [coreCfgPkg::regIdxW-1:0] rd,
    input  logic [coreCfgPkg::xlen-1:0]    writeData,
    output logic [coreCfgPkg::xlen-1:0]    readData1,
    output logic [coreCfgPkg::xlen-1:0]    readData2
);

    logic [coreCfgPkg::xlen-1:0] regs [coreCfgPkg::regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < coreCfgPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != '0) begin  // x0 stays zero
            regs[rd] <= writeData;
        end
    end

    assign readData1 = regs[rs1];
    assign readData2 = regs[rs2];

endmodule

// File: core/alu.sv
module alu (
    input  logic [coreCfgPkg::xlen-1:0] srcA,
    input  logic [coreCfgPkg::xlen-1:0] srcB,
    input  coreCfgPkg::aluOpT           aluOp,
    input  rvIsaPkg::branchFunct3T      branchFunct,
    output logic [coreCfgPkg::xlen-1:0] result,
    output logic                        branchFlag
);

    logic                          equal;
    logic                          lessSigned;
    logic                          lessUnsigned;
    logic [coreCfgPkg::shamtW-1:0] shamt;

    assign equal        = srcA == srcB;
    assign lessSigned   = $signed(srcA) < $signed(srcB);
    assign lessUnsigned = srcA < srcB;
    assign shamt        = srcB[coreCfgPkg::shamtW-1:0];

    always_comb begin
        case (aluOp)
            coreCfgPkg::aluAdd:   result = srcA + srcB;
            coreCfgPkg::aluSub:   result = srcA - srcB;
            coreCfgPkg::aluAnd:   result = srcA & srcB;
            coreCfgPkg::aluOr:    result = srcA | srcB;
            coreCfgPkg::aluXor:   result = srcA ^ srcB;
            coreCfgPkg::aluSlt:   result = {{(coreCfgPkg::xlen-1){1'b0}}, lessSigned};
            coreCfgPkg::aluSltu:  result = {{(coreCfgPkg::xlen-1){1'b0}}, lessUnsigned};
            coreCfgPkg::aluSll:   result = srcA << shamt;
            coreCfgPkg::aluSrl:   result = srcA >> shamt;
            coreCfgPkg::aluSra:   result = $signed(srcA) >>> shamt;
            coreCfgPkg::aluPassB: result = srcB;
            default:              result = '0;
        endcase
    end

    // operands here are the two registers, since branches never select the immediate
    always_comb begin
        case (branchFunct)
            rvIsaPkg::f3Beq:  branchFlag = equal;
            rvIsaPkg::f3Bne:  branchFlag = !equal;
            rvIsaPkg::f3Blt:  branchFlag = lessSigned;
            rvIsaPkg::f3Bge:  branchFlag = !lessSigned;
            rvIsaPkg::f3Bltu: branchFlag = lessUnsigned;
            rvIsaPkg::f3Bgeu: branchFlag = !lessUnsigned;
            default:          branchFlag = 1'b0;
        endcase
    end

endmodule

// File: common/coreCfgPkg.sv
package coreCfgPkg;

    localparam int xlen     = 32;
    localparam int regCount = 32;
    localparam int regIdxW  = $clog2(regCount);
    localparam int shamtW   = $clog2(xlen);

    localparam logic [xlen-1:0] resetPc = '0;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB  // lui hands the immediate straight through
    } aluOpT;

    // one bundle per decoded instruction
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;    // operand B is the immediate
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  jal;
        logic  jalr;
        logic  branch;    // set only for a taken branch
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic [xlen-1:0] address;
        logic [xlen-1:0] storeData;
        logic            read;
        logic            write;
    } dataReqT;

endpackage

// File: common/rvIsaPkg.sv
package rvIsaPkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [2:0] {
        f3Add  = 3'b000,  // add, sub and addi
        f3Sll  = 3'b001,
        f3Slt  = 3'b010,
        f3Sltu = 3'b011,
        f3Xor  = 3'b100,
        f3Sr   = 3'b101,  // srl or sra, picked by funct7
        f3Or   = 3'b110,
        f3And  = 3'b111
    } aluFunct3T;

    typedef enum logic [2:0] {
        f3Beq  = 3'b000,
        f3Bne  = 3'b001,
        f3Blt  = 3'b100,
        f3Bge  = 3'b101,
        f3Bltu = 3'b110,
        f3Bgeu = 3'b111
    } branchFunct3T;

    localparam int opcodeLsb = 0;
    localparam int opcodeMsb = 6;
    localparam int rdLsb     = 7;
    localparam int rdMsb     = 11;
    localparam int funct3Lsb = 12;
    localparam int funct3Msb = 14;
    localparam int rs1Lsb    = 15;
    localparam int rs1Msb    = 19;
    localparam int rs2Lsb    = 20;
    localparam int rs2Msb    = 24;
    localparam int funct7Lsb = 25;
    localparam int funct7Msb = 31;

    localparam logic [6:0] funct7Alt = 7'b0100000;  // selects sub and sra

endpackage
